// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbExecCore
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu.sv
`timescale 1ns/1ps

module alu
    import mipsPkg::*;
(
    input  wordT    a,
    input  wordT    b,
    input  aluFuncT func,
    output wordT    y,
    output logic    ov
);

    wordT sum;
    wordT diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (func)
            aluAdd:   y = sum;
            aluSub:   y = diff;
            aluAnd:   y = a & b;
            aluOr:    y = a | b;
            aluXor:   y = a ^ b;
            aluNor:   y = ~(a | b);
            aluSlt:   y = {31'b0, $signed(a) < $signed(b)};
            aluSltu:  y = {31'b0, a < b};
            // shift amount comes in on a, value on b
            aluSll:   y = b << a[4:0];
            aluSrl:   y = b >> a[4:0];
            aluSra:   y = $signed(b) >>> a[4:0];
            aluLui:   y = {b[15:0], 16'b0};
            aluPassB: y = b;
            default:  y = '0;
        endcase
    end

    // signed overflow when operand signs agree (differ for sub) and the result sign flips
    always_comb begin
        case (func)
            aluAdd:  ov = (a[31] == b[31]) && (sum[31] != a[31]);
            aluSub:  ov = (a[31] != b[31]) && (diff[31] != a[31]);
            default: ov = 1'b0;
        endcase
    end

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage
    import mipsPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       inReq,
    input  fetchT      inData,
    input  logic       stall,
    output logic       inAck,
    output logic       dValid,
    output decodeDataT dData
);

    typedef enum logic {hsIdle, hsWaitLow} hsStateT;

    hsStateT      hsState;
    logic         accept;
    logic [5:0]   opcode;
    logic [5:0]   funct;
    logic [15:0]  imm;
    decodeDataT   decoded;

    // latch only when the decode register frees up this cycle
    assign accept = (hsState == hsIdle) && inReq && (!dValid || !stall);
    assign inAck = (hsState == hsWaitLow);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            hsState <= hsIdle;
        end else if (accept) begin
            hsState <= hsWaitLow;
        end else if (hsState == hsWaitLow && !inReq) begin
            hsState <= hsIdle;
        end
    end

    assign opcode = inData.instr[31:26];
    assign funct  = inData.instr[5:0];
    assign imm    = inData.instr[15:0];

    always_comb begin
        decoded = '0;
        decoded.pc = inData.pc;
        decoded.instr.rs = inData.instr[25:21];
        decoded.instr.rt = inData.instr[20:16];
        decoded.instr.rd = inData.instr[15:11];
        decoded.instr.shamt = inData.instr[10:6];
        decoded.instr.extImm = {{16{imm[15]}}, imm};
        decoded.instr.aluFunc = aluAdd;
        decoded.instr.aluSrcB = srcBImm;
        decoded.instr.regDst = regDstRt;
        decoded.instr.regWrite = 1'b1;
        case (opcode)
            6'h00: begin
                decoded.instr.aluSrcB = srcBReg;
                decoded.instr.regDst = regDstRd;
                case (funct)
                    6'h00: begin
                        decoded.instr.aluFunc = aluSll;
                        decoded.instr.shamtValid = 1'b1;
                    end
                    6'h02: begin
                        decoded.instr.aluFunc = aluSrl;
                        decoded.instr.shamtValid = 1'b1;
                    end
                    6'h03: begin
                        decoded.instr.aluFunc = aluSra;
                        decoded.instr.shamtValid = 1'b1;
                    end
                    6'h20: begin
                        decoded.instr.aluFunc = aluAdd;
                        decoded.instr.checkOv = 1'b1;
                    end
                    6'h21: decoded.instr.aluFunc = aluAdd;
                    6'h22: begin
                        decoded.instr.aluFunc = aluSub;
                        decoded.instr.checkOv = 1'b1;
                    end
                    6'h23: decoded.instr.aluFunc = aluSub;
                    6'h24: decoded.instr.aluFunc = aluAnd;
                    6'h25: decoded.instr.aluFunc = aluOr;
                    6'h26: decoded.instr.aluFunc = aluXor;
                    6'h27: decoded.instr.aluFunc = aluNor;
                    6'h2a: decoded.instr.aluFunc = aluSlt;
                    6'h2b: decoded.instr.aluFunc = aluSltu;
                    default: begin
                        decoded.instr.riExc = 1'b1;
                        decoded.instr.regWrite = 1'b0;
                    end
                endcase
            end
            6'h08: decoded.instr.checkOv = 1'b1;
            6'h09: decoded.instr.aluFunc = aluAdd;
            6'h0a: decoded.instr.aluFunc = aluSlt;
            // sltiu compares unsigned against the sign-extended immediate
            6'h0b: decoded.instr.aluFunc = aluSltu;
            6'h0c: begin
                decoded.instr.aluFunc = aluAnd;
                decoded.instr.extImm = {16'h0, imm};
            end
            6'h0d: begin
                decoded.instr.aluFunc = aluOr;
                decoded.instr.extImm = {16'h0, imm};
            end
            6'h0e: begin
                decoded.instr.aluFunc = aluXor;
                decoded.instr.extImm = {16'h0, imm};
            end
            6'h0f: decoded.instr.aluFunc = aluLui;
            6'h03: begin
                decoded.instr.aluFunc = aluPassB;
                decoded.instr.regDst = regDstR31;
                decoded.instr.link = 1'b1;
            end
            default: begin
                decoded.instr.riExc = 1'b1;
                decoded.instr.regWrite = 1'b0;
            end
        endcase
    end

    // execute drains the register every cycle it is not stalled
    pipeReg #(.payloadT(decodeDataT)) decodeReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (accept),
        .inData   (decoded),
        .stall    (stall),
        .take     (1'b1),
        .outValid (dValid),
        .outData  (dData)
    );

endmodule

// File: execCore.sv
`timescale 1ns/1ps

module execCore
    import mipsPkg::*;
(
    input  logic   clk,
    input  logic   rstN,
    input  logic   inReq,
    input  fetchT  inData,
    input  logic   retAck,
    output logic   inAck,
    output logic   retReq,
    output retireT retData
);

    logic       dValid;
    decodeDataT dData;
    logic       stallE;
    cregAddrT   raddrA;
    cregAddrT   raddrB;
    wordT       rdataA;
    wordT       rdataB;
    forwardT    forwardA;
    forwardT    forwardB;
    execDataT   eData;
    logic       wen;
    cregAddrT   waddr;
    wordT       wdata;
    logic       wbValid;
    logic       wbRegWrite;
    cregAddrT   wbWriteReg;
    wordT       wbResult;

    decodeStage decodeStage (
        .clk    (clk),
        .rstN   (rstN),
        .inReq  (inReq),
        .inData (inData),
        .stall  (stallE),
        .inAck  (inAck),
        .dValid (dValid),
        .dData  (dData)
    );

    regFile regFile (
        .clk    (clk),
        .rstN   (rstN),
        .raddrA (raddrA),
        .raddrB (raddrB),
        .wen    (wen),
        .waddr  (waddr),
        .wdata  (wdata),
        .rdataA (rdataA),
        .rdataB (rdataB)
    );

    hazardUnit hazardUnit (
        .rsE        (dData.instr.rs),
        .rtE        (dData.instr.rt),
        .wbValid    (wbValid),
        .wbRegWrite (wbRegWrite),
        .wbWriteReg (wbWriteReg),
        .forwardA   (forwardA),
        .forwardB   (forwardB)
    );

    execute execute (
        .dValid   (dValid),
        .dData    (dData),
        .rdataA   (rdataA),
        .rdataB   (rdataB),
        .forwardA (forwardA),
        .forwardB (forwardB),
        .wbResult (wbResult),
        .raddrA   (raddrA),
        .raddrB   (raddrB),
        .eData    (eData)
    );

    writebackStage writebackStage (
        .clk        (clk),
        .rstN       (rstN),
        .eValid     (dValid),
        .eData      (eData),
        .retAck     (retAck),
        .retReq     (retReq),
        .retData    (retData),
        .stall      (stallE),
        .wen        (wen),
        .waddr      (waddr),
        .wdata      (wdata),
        .wbValid    (wbValid),
        .wbRegWrite (wbRegWrite),
        .wbWriteReg (wbWriteReg),
        .wbResult   (wbResult)
    );

endmodule

// File: execute.sv
`timescale 1ns/1ps

module execute
    import mipsPkg::*;
(
    input  logic       dValid,
    input  decodeDataT dData,
    input  wordT       rdataA,
    input  wordT       rdataB,
    input  forwardT    forwardA,
    input  forwardT    forwardB,
    input  wordT       wbResult,
    output cregAddrT   raddrA,
    output cregAddrT   raddrB,
    output execDataT   eData
);

    decodedInstrT instr;
    wordT srcA;
    wordT srcB;
    wordT aluA;
    wordT aluB;
    wordT aluY;
    logic aluOv;
    cregAddrT writeReg;
    excCodeT exc;

    assign instr  = dData.instr;
    assign raddrA = instr.rs;
    assign raddrB = instr.rt;

    assign srcA = (forwardA == fwdWriteback) ? wbResult : rdataA;
    assign srcB = (forwardB == fwdWriteback) ? wbResult : rdataB;

    assign aluA = instr.shamtValid ? {27'b0, instr.shamt} : srcA;
    assign aluB = (instr.aluSrcB == srcBImm) ? instr.extImm : srcB;

    alu alu (
        .a    (aluA),
        .b    (aluB),
        .func (instr.aluFunc),
        .y    (aluY),
        .ov   (aluOv)
    );

    always_comb begin
        case (instr.regDst)
            regDstRd:  writeReg = instr.rd;
            regDstR31: writeReg = 5'd31;
            default:   writeReg = instr.rt;
        endcase
    end

    always_comb begin
        if (instr.riExc) begin
            exc = excReservedInstr;
        end else if (instr.checkOv && aluOv) begin
            exc = excOverflow;
        end else begin
            exc = excNone;
        end
    end

    assign eData.pc       = dData.pc;
    assign eData.writeReg = writeReg;
    // jal links the address after the delay slot
    assign eData.result   = instr.link ? dData.pc + 32'd8 : aluY;
    // bubbles and excepting instructions never write
    assign eData.regWrite = dValid && instr.regWrite && (exc == excNone);
    assign eData.exc      = exc;

endmodule

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
    import mipsPkg::*;
(
    input  cregAddrT rsE,
    input  cregAddrT rtE,
    input  logic     wbValid,
    input  logic     wbRegWrite,
    input  cregAddrT wbWriteReg,
    output forwardT  forwardA,
    output forwardT  forwardB
);

    logic wbLive;

    // only a pending write to a real register can be forwarded
    assign wbLive = wbValid && wbRegWrite && (wbWriteReg != 5'd0);

    always_comb begin
        forwardA = fwdRegfile;
        forwardB = fwdRegfile;
        if (wbLive && wbWriteReg == rsE) begin
            forwardA = fwdWriteback;
        end
        if (wbLive && wbWriteReg == rtE) begin
            forwardB = fwdWriteback;
        end
    end

endmodule

// File: mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  cregAddrT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluLui,
        aluPassB
    } aluFuncT;

    typedef enum logic [1:0] {
        excNone,
        excReservedInstr,
        excOverflow
    } excCodeT;

    typedef enum logic [1:0] {
        regDstRt,
        regDstRd,
        regDstR31
    } regDstT;

    typedef enum logic {
        srcBReg,
        srcBImm
    } aluSrcBT;

    typedef enum logic {
        fwdRegfile,
        fwdWriteback
    } forwardT;

    // input payload from the fetch side
    typedef struct packed {
        wordT pc;
        wordT instr;
    } fetchT;

    typedef struct packed {
        cregAddrT rs;
        cregAddrT rt;
        cregAddrT rd;
        logic [4:0] shamt;
        wordT extImm;
        aluFuncT aluFunc;
        aluSrcBT aluSrcB;
        regDstT regDst;
        logic shamtValid;
        logic checkOv;
        logic regWrite;
        logic link;
        logic riExc;
    } decodedInstrT;

    typedef struct packed {
        decodedInstrT instr;
        wordT pc;
    } decodeDataT;

    typedef struct packed {
        wordT pc;
        cregAddrT writeReg;
        wordT result;
        logic regWrite;
        excCodeT exc;
    } execDataT;

    // retired record is exactly the writeback entry
    typedef execDataT retireT;

endpackage

// File: pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    inValid,
    input  payloadT inData,
    input  logic    stall,
    input  logic    take,
    output logic    outValid,
    output payloadT outData
);

    logic free;

    // empty, or the held entry leaves this cycle
    assign free = !outValid || (take && !stall);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (free) begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (free && inValid) begin
            outData <= inData;
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  cregAddrT raddrA,
    input  cregAddrT raddrB,
    input  logic     wen,
    input  cregAddrT waddr,
    input  wordT     wdata,
    output wordT     rdataA,
    output wordT     rdataB
);

    wordT regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads as zero and reads see the value before this edge's write
    assign rdataA = (raddrA == 5'd0) ? '0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? '0 : regs[raddrB];

endmodule

// File: tbExecCore.sv
`timescale 1ns/1ps

module tbExecCore
    import mipsPkg::*;
();

    localparam int numInstr  = 400;
    localparam int waitLimit = 200;
    localparam logic [5:0] rFuncts [13] = '{6'h21, 6'h20, 6'h23, 6'h22, 6'h24, 6'h25, 6'h26,
                                            6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
    localparam logic [5:0] iOps [8] = '{6'h09, 6'h08, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0b, 6'h0f};

    logic   clk;
    logic   rstN;
    logic   inReq;
    fetchT  inData;
    logic   retAck;
    logic   inAck;
    logic   retReq;
    retireT retData;

    wordT   progInstr [numInstr];
    retireT expected [numInstr];
    int     gapCycles [numInstr];
    int     ackDelay [numInstr];
    wordT   modelRegs [32];
    logic   extraRetire;

    execCore DUT (
        .clk     (clk),
        .rstN    (rstN),
        .inReq   (inReq),
        .inData  (inData),
        .retAck  (retAck),
        .inAck   (inAck),
        .retReq  (retReq),
        .retData (retData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compareWord(input int idx, input string field, input wordT got,
                               input wordT want);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0d ns: retirement %0d %s is %h, expected %h",
                               $time, idx, field, got, want));
        end
    endtask

    task automatic compareAddr(input int idx, input string field, input cregAddrT got,
                               input cregAddrT want);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0d ns: retirement %0d %s is r%0d, expected r%0d",
                               $time, idx, field, got, want));
        end
    endtask

    task automatic compareFlag(input int idx, input string field, input logic got,
                               input logic want);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0d ns: retirement %0d %s is %b, expected %b",
                               $time, idx, field, got, want));
        end
    endtask

    task automatic compareExc(input int idx, input excCodeT got, input excCodeT want);
        if (got !== want) begin
            abortRun($sformatf("FAILED at %0d ns: retirement %0d exc is %s, expected %s",
                               $time, idx, got.name(), want.name()));
        end
    endtask

    // destination and result only mean something when nothing excepted
    task automatic compareRetire(input int idx, input retireT got, input retireT want);
        compareWord(idx, "pc", got.pc, want.pc);
        compareExc(idx, got.exc, want.exc);
        compareFlag(idx, "regWrite", got.regWrite, want.regWrite);
        if (want.exc == excNone) begin
            compareAddr(idx, "writeReg", got.writeReg, want.writeReg);
            compareWord(idx, "result", got.result, want.result);
        end
    endtask

    function automatic wordT pcOf(input int idx);
        return 32'h0040_0000 + 32'(idx) * 32'd4;
    endfunction

    // true sum against the sign-extended 32-bit wrap
    function automatic logic signedOverflow(input wordT x, input wordT y, input logic isSub);
        longint exact;
        wordT wrapped;
        exact = isSub ? longint'($signed(x)) - longint'($signed(y))
                      : longint'($signed(x)) + longint'($signed(y));
        wrapped = isSub ? x - y : x + y;
        return exact != longint'($signed(wrapped));
    endfunction

    function automatic wordT randomInstr();
        cregAddrT rs;
        cregAddrT rt;
        cregAddrT rd;
        logic [4:0] sh;
        logic [15:0] imm;
        int pick;
        // r0..r7 only so dependences stay dense
        rs = 5'($urandom_range(0, 7));
        rt = 5'($urandom_range(0, 7));
        rd = 5'($urandom_range(0, 7));
        sh = 5'($urandom);
        imm = 16'($urandom);
        pick = $urandom_range(0, 99);
        if (pick < 5) begin
            // j, lw, sw, unused opcode, mult, jr
            case ($urandom_range(0, 5))
                0: return {6'h02, 26'($urandom)};
                1: return {6'h23, rs, rt, imm};
                2: return {6'h2b, rs, rt, imm};
                3: return {6'h3f, rs, rt, imm};
                4: return {6'h00, rs, rt, rd, sh, 6'h18};
                default: return {6'h00, rs, rt, rd, sh, 6'h08};
            endcase
        end
        pick = $urandom_range(0, 21);
        if (pick < 13) begin
            return {6'h00, rs, rt, rd, sh, rFuncts[pick[3:0]]};
        end else if (pick < 21) begin
            return {iOps[3'(pick - 13)], rs, rt, imm};
        end
        return {6'h03, 26'($urandom)};
    endfunction

    task automatic modelStep(input int idx, input wordT instr, input wordT pc);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] sh;
        cregAddrT rs;
        cregAddrT rt;
        cregAddrT dst;
        wordT a;
        wordT b;
        wordT sImm;
        wordT zImm;
        wordT res;
        logic ovf;
        logic legal;
        op = instr[31:26];
        fn = instr[5:0];
        sh = instr[10:6];
        rs = instr[25:21];
        rt = instr[20:16];
        a = modelRegs[rs];
        b = modelRegs[rt];
        sImm = {{16{instr[15]}}, instr[15:0]};
        zImm = {16'h0, instr[15:0]};
        res = '0;
        dst = rt;
        ovf = 1'b0;
        legal = 1'b1;
        case (op)
            6'h00: begin
                dst = instr[15:11];
                case (fn)
                    6'h00: res = b << sh;
                    6'h02: res = b >> sh;
                    6'h03: res = $signed(b) >>> sh;
                    6'h20, 6'h21: res = a + b;
                    6'h22, 6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2b: res = (a < b) ? 32'd1 : 32'd0;
                    default: legal = 1'b0;
                endcase
                if (fn == 6'h20 || fn == 6'h22) begin
                    ovf = signedOverflow(a, b, fn == 6'h22);
                end
            end
            6'h08: begin
                res = a + sImm;
                ovf = signedOverflow(a, sImm, 1'b0);
            end
            6'h09: res = a + sImm;
            6'h0a: res = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
            6'h0b: res = (a < sImm) ? 32'd1 : 32'd0;
            6'h0c: res = a & zImm;
            6'h0d: res = a | zImm;
            6'h0e: res = a ^ zImm;
            6'h0f: res = {instr[15:0], 16'h0};
            6'h03: begin
                dst = 5'd31;
                res = pc + 32'd8;
            end
            default: legal = 1'b0;
        endcase
        expected[idx].pc = pc;
        expected[idx].writeReg = dst;
        expected[idx].result = res;
        expected[idx].regWrite = legal && !ovf;
        expected[idx].exc = !legal ? excReservedInstr : (ovf ? excOverflow : excNone);
        if (legal && !ovf && dst != 5'd0) begin
            modelRegs[dst] = res;
        end
    endtask

    task automatic waitInAck(input logic level);
        int cycles;
        cycles = 0;
        while (inAck !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun($sformatf("Timed out waiting for inAck to go %0b", level));
            end
        end
    endtask

    task automatic waitRetReq(input logic level);
        int cycles;
        cycles = 0;
        while (retReq !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > waitLimit) begin
                abortRun($sformatf("Timed out waiting for retReq to go %0b", level));
            end
        end
    endtask

    task automatic driveProgram();
        for (int i = 0; i < numInstr; i++) begin
            repeat (gapCycles[i]) @(negedge clk);
            inData.pc = pcOf(i);
            inData.instr = progInstr[i];
            inReq = 1'b1;
            waitInAck(1'b1);
            inReq = 1'b0;
            waitInAck(1'b0);
        end
    endtask

    // one retirement per pass, checked in program order
    task automatic respondRetire();
        for (int n = 0; n < numInstr; n++) begin
            waitRetReq(1'b1);
            repeat (ackDelay[n]) @(negedge clk);
            compareRetire(n, retData, expected[n]);
            retAck = 1'b1;
            waitRetReq(1'b0);
            retAck = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(93881));
        rstN = 1'b0;
        inReq = 1'b0;
        inData = '0;
        retAck = 1'b0;
        extraRetire = 1'b0;
        for (int r = 0; r < 32; r++) begin
            modelRegs[r] = '0;
        end
        for (int i = 0; i < numInstr; i++) begin
            progInstr[i] = randomInstr();
            gapCycles[i] = $urandom_range(0, 3);
            ackDelay[i] = $urandom_range(0, 4);
            modelStep(i, progInstr[i], pcOf(i));
        end
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        if (inAck !== 1'b0 || retReq !== 1'b0) begin
            abortRun("Handshake outputs were not idle after reset");
        end
        fork
            driveProgram();
            respondRetire();
        join
        // a late request here would be a duplicate
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            if (retReq !== 1'b0) begin
                extraRetire = 1'b1;
            end
        end
        if (!extraRetire) begin
            $display("Regression passed");
            $finish;
        end else begin
            abortRun("Saw an unexpected retirement request after the last instruction");
        end
    end

endmodule

// File: vlog.f
mipsPkg.sv
pipeReg.sv
regFile.sv
alu.sv
hazardUnit.sv
decodeStage.sv
execute.sv
writebackStage.sv
execCore.sv
tbExecCore.sv

// File: writebackStage.sv
`timescale 1ns/1ps

module writebackStage
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     eValid,
    input  execDataT eData,
    input  logic     retAck,
    output logic     retReq,
    output retireT   retData,
    output logic     stall,
    output logic     wen,
    output cregAddrT waddr,
    output wordT     wdata,
    output logic     wbValid,
    output logic     wbRegWrite,
    output cregAddrT wbWriteReg,
    output wordT     wbResult
);

    execDataT wbData;
    logic     retire;

    // entry leaves while retAck is high and holds otherwise
    pipeReg #(.payloadT(execDataT)) wbReg (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (eValid),
        .inData   (eData),
        .stall    (!retAck),
        .take     (retReq),
        .outValid (wbValid),
        .outData  (wbData)
    );

    assign retire = retReq && retAck;

    // next request waits for the previous ack to drop
    always_ff @(posedge clk) begin
        if (!rstN) begin
            retReq <= 1'b0;
        end else if (retReq) begin
            retReq <= !retAck;
        end else begin
            retReq <= wbValid && !retAck;
        end
    end

    assign retData    = wbData;
    assign stall      = wbValid && !retire;
    assign wen        = retire && wbData.regWrite;
    assign waddr      = wbData.writeReg;
    assign wdata      = wbData.result;
    assign wbRegWrite = wbData.regWrite;
    assign wbWriteReg = wbData.writeReg;
    assign wbResult   = wbData.result;

endmodule
